// File: hw/sa_config.svh
`ifndef SA_CONFIG_SVH
`define SA_CONFIG_SVH

// rows and columns of the square PE array
`define SA_PE_SIZE 4

// one weight or one activation
`define SA_DATA_WIDTH 8

// partial sums and result elements, wide enough that a full column never wraps
// for the default array size
`define SA_PSUM_WIDTH 32

`endif

// File: hw/sa_pkg.sv
`include "sa_config.svh"

package sa_pkg;

    // scalar words
    typedef logic [`SA_DATA_WIDTH-1:0] data_t;
    typedef logic [`SA_PSUM_WIDTH-1:0] psum_t;

    // lane 0 sits in the low bits
    typedef data_t [`SA_PE_SIZE-1:0] data_vec_t;
    typedef psum_t [`SA_PE_SIZE-1:0] psum_vec_t;

    // load sequencing
    typedef enum logic [1:0] {
        CTRL_IDLE  = 2'd0,
        CTRL_LOAD  = 2'd1,
        CTRL_READY = 2'd2
    } ctrl_state_t;

endpackage

// File: hw/pe.sv
`include "sa_config.svh"

module pe (
    input  logic          clk,
    input  logic          reset_i,
    input  sa_pkg::data_t weight_i,
    input  logic          weight_en_i,
    input  sa_pkg::data_t ifmap_i,
    input  logic          ifmap_en_i,
    input  sa_pkg::psum_t psum_i,
    output sa_pkg::data_t weight_o,
    output sa_pkg::data_t ifmap_o,
    output logic          ifmap_en_o,
    output sa_pkg::psum_t psum_o,
    output logic          psum_en_o
);

    sa_pkg::data_t                weight_q;
    sa_pkg::data_t                ifmap_q;
    sa_pkg::psum_t                psum_q;
    logic                         en_q;
    logic [2*`SA_DATA_WIDTH-1:0]  product;

    // unsigned product, zero extended into the psum
    assign product = weight_q * ifmap_i;

    // stationary weight, the old value moves to the PE below on a load
    always_ff @(posedge clk) begin
        if (reset_i) begin
            weight_q <= '0;
        end else if (weight_en_i) begin
            weight_q <= weight_i;
        end
    end

    // activation and psum only move with a valid activation
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ifmap_q <= '0;
            psum_q  <= '0;
        end else if (ifmap_en_i) begin
            ifmap_q <= ifmap_i;
            psum_q  <= psum_i + sa_pkg::psum_t'(product);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            en_q <= 1'b0;
        end else begin
            en_q <= ifmap_en_i;
        end
    end

    assign weight_o   = weight_q;
    assign ifmap_o    = ifmap_q;
    assign psum_o     = psum_q;
    // one enable register serves both directions
    assign ifmap_en_o = en_q;
    assign psum_en_o  = en_q;

endmodule

// File: hw/systolic_array.sv
`include "sa_config.svh"

module systolic_array (
    input  logic                   clk,
    input  logic                   reset_i,
    input  sa_pkg::data_vec_t      weight_row_i,
    input  logic                   weight_en_i,
    input  sa_pkg::data_vec_t      ifmap_vec_i,
    input  logic [`SA_PE_SIZE-1:0] ifmap_en_i,
    output sa_pkg::psum_vec_t      psum_vec_o,
    output logic [`SA_PE_SIZE-1:0] psum_en_o
);

    localparam int PE_SIZE = `SA_PE_SIZE;

    // weights and psums run down the columns, indexed [row][col]
    sa_pkg::data_t weight_w   [PE_SIZE+1][PE_SIZE];
    sa_pkg::psum_t psum_w     [PE_SIZE+1][PE_SIZE];
    logic          psum_en_w  [PE_SIZE][PE_SIZE];

    // activations run along the rows, indexed [row][col]
    sa_pkg::data_t ifmap_w    [PE_SIZE][PE_SIZE+1];
    logic          ifmap_en_w [PE_SIZE][PE_SIZE+1];

    // top edge: new weight row in, psum chain starts from zero
    for (genvar c = 0; c < PE_SIZE; c++) begin : gen_top_edge
        assign weight_w[0][c] = weight_row_i[c];
        assign psum_w[0][c]   = '0;
    end

    // left edge: one activation lane per row
    for (genvar r = 0; r < PE_SIZE; r++) begin : gen_left_edge
        assign ifmap_w[r][0]    = ifmap_vec_i[r];
        assign ifmap_en_w[r][0] = ifmap_en_i[r];
    end

    for (genvar r = 0; r < PE_SIZE; r++) begin : gen_row
        for (genvar c = 0; c < PE_SIZE; c++) begin : gen_col
            pe i_pe (
                .clk         (clk),
                .reset_i     (reset_i),
                .weight_i    (weight_w[r][c]),
                // every PE shifts together on a row load
                .weight_en_i (weight_en_i),
                .ifmap_i     (ifmap_w[r][c]),
                .ifmap_en_i  (ifmap_en_w[r][c]),
                .psum_i      (psum_w[r][c]),
                .weight_o    (weight_w[r+1][c]),
                .ifmap_o     (ifmap_w[r][c+1]),
                .ifmap_en_o  (ifmap_en_w[r][c+1]),
                .psum_o      (psum_w[r+1][c]),
                .psum_en_o   (psum_en_w[r][c])
            );
        end
    end

    // bottom edge carries the column sums out
    // activations leaving the right edge and weights leaving the bottom are dropped
    for (genvar c = 0; c < PE_SIZE; c++) begin : gen_bottom_edge
        assign psum_vec_o[c] = psum_w[PE_SIZE][c];
        assign psum_en_o[c]  = psum_en_w[PE_SIZE-1][c];
    end

endmodule

// File: hw/skew_buffer.sv
`include "sa_config.svh"

module skew_buffer #(
    parameter int LANE_WIDTH = 8,
    parameter bit DESCENDING = 1'b0
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic [LANE_WIDTH*`SA_PE_SIZE-1:0] lanes_i,
    input  logic [`SA_PE_SIZE-1:0]            en_i,
    output logic [LANE_WIDTH*`SA_PE_SIZE-1:0] lanes_o,
    output logic [`SA_PE_SIZE-1:0]            en_o
);

    localparam int PE_SIZE = `SA_PE_SIZE;

    for (genvar i = 0; i < PE_SIZE; i++) begin : gen_lane
        // ascending skews the input wavefront, descending lines it up again
        localparam int DELAY = DESCENDING ? (PE_SIZE - 1 - i) : i;

        if (DELAY == 0) begin : gen_pass
            assign lanes_o[i*LANE_WIDTH +: LANE_WIDTH] = lanes_i[i*LANE_WIDTH +: LANE_WIDTH];
            assign en_o[i]                             = en_i[i];
        end else begin : gen_delay
            logic [LANE_WIDTH-1:0] data_sr [DELAY];
            logic [DELAY-1:0]      en_sr;

            // data shifts every cycle, qualified by the enable beside it
            always_ff @(posedge clk) begin
                data_sr[0] <= lanes_i[i*LANE_WIDTH +: LANE_WIDTH];
                for (int s = 1; s < DELAY; s++) begin
                    data_sr[s] <= data_sr[s-1];
                end
            end

            always_ff @(posedge clk) begin
                if (reset_i) begin
                    en_sr <= '0;
                end else begin
                    en_sr[0] <= en_i[i];
                    for (int s = 1; s < DELAY; s++) begin
                        en_sr[s] <= en_sr[s-1];
                    end
                end
            end

            assign lanes_o[i*LANE_WIDTH +: LANE_WIDTH] = data_sr[DELAY-1];
            assign en_o[i]                             = en_sr[DELAY-1];
        end
    end

endmodule

// File: hw/sa_controller.sv
`include "sa_config.svh"

module sa_controller (
    input  logic clk,
    input  logic reset_i,
    input  logic weight_load_i,
    input  logic ifmap_valid_i,
    input  logic result_valid_i,
    output logic load_en_o,
    output logic accept_o,
    output logic weights_ready_o
);

    localparam int PE_SIZE = `SA_PE_SIZE;
    localparam int ROW_W   = (PE_SIZE > 1) ? $clog2(PE_SIZE) : 1;
    // pipeline holds fewer than 2*PE_SIZE vectors at once
    localparam int CNT_W   = $clog2(2 * PE_SIZE + 1);

    sa_pkg::ctrl_state_t state_q;
    sa_pkg::ctrl_state_t state_d;
    logic [ROW_W-1:0]    row_q;
    logic [ROW_W-1:0]    row_d;
    logic [ROW_W-1:0]    row_idx;
    logic [CNT_W-1:0]    inflight_q;
    logic                busy;

    assign busy            = (inflight_q != '0);
    assign weights_ready_o = (state_q == sa_pkg::CTRL_READY);

    // no reload while results still depend on the current weights
    assign load_en_o = weight_load_i && !(weights_ready_o && busy);
    assign accept_o  = ifmap_valid_i && weights_ready_o;

    // a load starting from idle or ready counts as row 0
    assign row_idx = (state_q == sa_pkg::CTRL_LOAD) ? row_q : '0;

    always_comb begin
        state_d = state_q;
        row_d   = row_q;
        if (load_en_o) begin
            if (row_idx == ROW_W'(PE_SIZE - 1)) begin
                // last row in place, array holds a full matrix
                state_d = sa_pkg::CTRL_READY;
                row_d   = '0;
            end else begin
                state_d = sa_pkg::CTRL_LOAD;
                row_d   = row_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= sa_pkg::CTRL_IDLE;
            row_q   <= '0;
        end else begin
            state_q <= state_d;
            row_q   <= row_d;
        end
    end

    // vectors between acceptance and result
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inflight_q <= '0;
        end else if (accept_o && !result_valid_i) begin
            inflight_q <= inflight_q + 1'b1;
        end else if (!accept_o && result_valid_i) begin
            inflight_q <= inflight_q - 1'b1;
        end
    end

endmodule

// File: hw/sa_top.sv
`include "sa_config.svh"

module sa_top (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              weight_load_i,
    input  sa_pkg::data_vec_t weight_row_i,
    input  logic              ifmap_valid_i,
    input  sa_pkg::data_vec_t ifmap_vec_i,
    output logic              weights_ready_o,
    output logic              result_valid_o,
    output sa_pkg::psum_vec_t result_vec_o
);

    localparam int PE_SIZE = `SA_PE_SIZE;

    logic               load_en;
    logic               accept;

    // skewed activations into the left edge
    sa_pkg::data_vec_t  ifmap_skew;
    logic [PE_SIZE-1:0] ifmap_en_skew;

    // raw column sums from the bottom edge
    sa_pkg::psum_vec_t  psum_bottom;
    logic [PE_SIZE-1:0] psum_en_bottom;

    // deskewed lanes, all bits rise together
    logic [PE_SIZE-1:0] result_en;

    sa_controller i_sa_controller (
        .clk             (clk),
        .reset_i         (reset_i),
        .weight_load_i   (weight_load_i),
        .ifmap_valid_i   (ifmap_valid_i),
        .result_valid_i  (result_valid_o),
        .load_en_o       (load_en),
        .accept_o        (accept),
        .weights_ready_o (weights_ready_o)
    );

    skew_buffer #(
        .LANE_WIDTH (`SA_DATA_WIDTH),
        .DESCENDING (1'b0)
    ) i_skew_in (
        .clk     (clk),
        .reset_i (reset_i),
        .lanes_i (ifmap_vec_i),
        .en_i    ({PE_SIZE{accept}}),
        .lanes_o (ifmap_skew),
        .en_o    (ifmap_en_skew)
    );

    systolic_array i_systolic_array (
        .clk          (clk),
        .reset_i      (reset_i),
        .weight_row_i (weight_row_i),
        .weight_en_i  (load_en),
        .ifmap_vec_i  (ifmap_skew),
        .ifmap_en_i   (ifmap_en_skew),
        .psum_vec_o   (psum_bottom),
        .psum_en_o    (psum_en_bottom)
    );

    skew_buffer #(
        .LANE_WIDTH (`SA_PSUM_WIDTH),
        .DESCENDING (1'b1)
    ) i_skew_out (
        .clk     (clk),
        .reset_i (reset_i),
        .lanes_i (psum_bottom),
        .en_i    (psum_en_bottom),
        .lanes_o (result_vec_o),
        .en_o    (result_en)
    );

    assign result_valid_o = result_en[0];

endmodule

// File: testbench/sa_assert.sv
`include "sa_config.svh"

module sa_assert (
    input logic                   clk,
    input logic                   reset_i,
    input logic                   load_en_i,
    input logic                   accept_i,
    input logic                   weights_ready_i,
    input logic                   result_valid_i,
    input logic [`SA_PE_SIZE-1:0] result_en_i
);

    localparam int PE_SIZE = `SA_PE_SIZE;
    localparam int ROWS_W  = $clog2(PE_SIZE + 1);

    // rows taken in by the current load, PE_SIZE once the matrix is complete
    logic [ROWS_W-1:0] rows_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rows_q <= '0;
        end else if (load_en_i) begin
            rows_q <= (rows_q == ROWS_W'(PE_SIZE)) ? ROWS_W'(1) : rows_q + 1'b1;
        end
    end

    // no ready level before the last row of a load is in place
    load_keeps_ready_low: assert property (
        @(posedge clk) disable iff (reset_i)
        (rows_q != ROWS_W'(PE_SIZE)) |-> !weights_ready_i
    ) else $error("weights_ready_o high while a weight load is in progress");

    // ready only comes up right after the last row of a load
    ready_follows_load: assert property (
        @(posedge clk) disable iff (reset_i)
        $rose(weights_ready_i) |-> $past(load_en_i)
    ) else $error("weights_ready_o rose without a weight row the cycle before");

    // every result traces back to an accepted vector
    result_has_source: assert property (
        @(posedge clk) disable iff (reset_i)
        result_valid_i |-> $past(accept_i, 2 * PE_SIZE - 1)
    ) else $error("result_valid_o high without an accepted vector in the pipeline");

    // enables are clear once reset has been seen at an edge
    reset_clears_enables: assert property (
        @(posedge clk)
        (reset_i && $past(reset_i)) |-> (result_en_i == '0)
    ) else $error("result enables not cleared during reset");

endmodule

bind sa_top sa_assert i_sa_assert (
    .clk             (clk),
    .reset_i         (reset_i),
    .load_en_i       (load_en),
    .accept_i        (accept),
    .weights_ready_i (weights_ready_o),
    .result_valid_i  (result_valid_o),
    .result_en_i     (result_en)
);

// File: testbench/sa_tb.sv
`include "sa_config.svh"

module sa_tb;

    localparam int PE_SIZE   = `SA_PE_SIZE;
    // vector on the inputs in cycle c, result on the outputs in cycle c + LATENCY
    localparam int LATENCY   = 2 * PE_SIZE - 1;
    localparam int MAX_STEPS = 96;

    typedef enum logic [1:0] {
        OP_LOAD,
        OP_VEC,
        OP_IDLE,
        OP_VEC_NOT_READY
    } op_t;

    logic              clk;
    logic              reset_i;
    logic              weight_load_i;
    sa_pkg::data_vec_t weight_row_i;
    logic              ifmap_valid_i;
    sa_pkg::data_vec_t ifmap_vec_i;
    logic              weights_ready_o;
    logic              result_valid_o;
    sa_pkg::psum_vec_t result_vec_o;

    // stimulus table
    string             step_name [MAX_STEPS];
    op_t               step_op   [MAX_STEPS];
    sa_pkg::data_vec_t step_data [MAX_STEPS];
    int                num_steps;
    integer            seed;

    // reference model, model_w[r] is the weight row held by array row r
    sa_pkg::data_vec_t model_w [PE_SIZE];
    logic              model_ready;
    int                model_rows;

    // expected results in output order
    sa_pkg::psum_vec_t exp_vec_q [$];
    int                exp_due_q [$];
    string             exp_name_q [$];

    string             cur_name;
    op_t               cur_op;
    int                cycle;
    int                max_cycles;
    int                busy;
    int                value_errors;
    int                protocol_errors;
    int                results_checked;

    sa_top i_sa_top (
        .clk             (clk),
        .reset_i         (reset_i),
        .weight_load_i   (weight_load_i),
        .weight_row_i    (weight_row_i),
        .ifmap_valid_i   (ifmap_valid_i),
        .ifmap_vec_i     (ifmap_vec_i),
        .weights_ready_o (weights_ready_o),
        .result_valid_o  (result_valid_o),
        .result_vec_o    (result_vec_o)
    );

    always #5 clk = ~clk;

    function automatic sa_pkg::data_vec_t random_vec();
        sa_pkg::data_vec_t v;
        for (int k = 0; k < PE_SIZE; k++) begin
            v[k] = sa_pkg::data_t'($random(seed));
        end
        return v;
    endfunction

    // y[j] = sum over k of a[k] * W[k][j], unsigned, wrapping at the psum width
    function automatic sa_pkg::psum_vec_t matvec(input sa_pkg::data_vec_t a);
        sa_pkg::psum_vec_t y;
        for (int j = 0; j < PE_SIZE; j++) begin
            y[j] = '0;
            for (int k = 0; k < PE_SIZE; k++) begin
                y[j] = y[j] + sa_pkg::psum_t'(a[k]) * sa_pkg::psum_t'(model_w[k][j]);
            end
        end
        return y;
    endfunction

    task automatic add_step(input string name, input op_t op, input sa_pkg::data_vec_t data);
        step_name[num_steps] = name;
        step_op[num_steps]   = op;
        step_data[num_steps] = data;
        num_steps++;
    endtask

    task automatic add_idle(input string name, input int n);
        for (int i = 0; i < n; i++) begin
            add_step(name, OP_IDLE, '0);
        end
    endtask

    task automatic build_table();
        add_idle("post_reset", 1);
        add_step("vec_before_load", OP_VEC_NOT_READY, random_vec());
        add_idle("idle_before_load", 2);
        for (int m = 0; m < PE_SIZE; m++) begin
            add_step($sformatf("load_a%0d", m), OP_LOAD, random_vec());
        end
        add_step("single_vec", OP_VEC, random_vec());
        add_idle("drain_single", 2 * PE_SIZE);
        for (int b = 0; b < 4; b++) begin
            add_step($sformatf("burst%0d", b), OP_VEC, random_vec());
        end
        add_idle("drain_burst", 2 * PE_SIZE);
        // results must keep the same gaps
        add_step("gap_vec0", OP_VEC, random_vec());
        add_idle("gap_two", 2);
        add_step("gap_vec1", OP_VEC, random_vec());
        add_idle("gap_three", 3);
        add_step("gap_vec2", OP_VEC, random_vec());
        add_idle("drain_gaps", 2 * PE_SIZE);
        // reload attempts with results still in flight
        add_step("inflight_vec0", OP_VEC, random_vec());
        add_step("inflight_vec1", OP_VEC, random_vec());
        add_step("load_blocked0", OP_LOAD, random_vec());
        add_idle("hold", 1);
        add_step("load_blocked1", OP_LOAD, random_vec());
        add_idle("drain_old", 2 * PE_SIZE);
        // full reload, one vector tried halfway through
        add_step("load_b0", OP_LOAD, random_vec());
        add_step("load_b1", OP_LOAD, random_vec());
        add_step("vec_mid_load", OP_VEC_NOT_READY, random_vec());
        add_step("load_b2", OP_LOAD, random_vec());
        add_step("load_b3", OP_LOAD, random_vec());
        add_step("new_w0", OP_VEC, random_vec());
        add_step("new_w1", OP_VEC, random_vec());
        add_idle("new_gap", 1);
        add_step("new_w2", OP_VEC, random_vec());
    endtask

    task automatic drive_step(input int i);
        @(posedge clk);
        cur_name      <= step_name[i];
        cur_op        <= step_op[i];
        weight_load_i <= (step_op[i] == OP_LOAD);
        weight_row_i  <= (step_op[i] == OP_LOAD) ? step_data[i] : '0;
        ifmap_valid_i <= (step_op[i] == OP_VEC) || (step_op[i] == OP_VEC_NOT_READY);
        ifmap_vec_i   <= (step_op[i] == OP_LOAD) ? '0 : step_data[i];
    endtask

    task automatic drive_idle();
        @(posedge clk);
        cur_name      <= "final_drain";
        cur_op        <= OP_IDLE;
        weight_load_i <= 1'b0;
        weight_row_i  <= '0;
        ifmap_valid_i <= 1'b0;
        ifmap_vec_i   <= '0;
    endtask

    task automatic pop_expected();
        void'(exp_vec_q.pop_front());
        void'(exp_due_q.pop_front());
        void'(exp_name_q.pop_front());
    endtask

    task automatic check_outputs();
        if (weights_ready_o !== model_ready) begin
            $display("mismatch step=%s weights_ready_o expected=%0b actual=%0b",
                     cur_name, model_ready, weights_ready_o);
            value_errors++;
        end
        if (result_valid_o === 1'b1) begin
            if (exp_vec_q.size() == 0) begin
                $display("result_valid_o high in cycle %0d with no vector in flight", cycle);
                protocol_errors++;
            end else begin
                if (exp_due_q[0] != cycle) begin
                    $display("result for step %s came in cycle %0d instead of cycle %0d",
                             exp_name_q[0], cycle, exp_due_q[0]);
                    protocol_errors++;
                end
                if (result_vec_o !== exp_vec_q[0]) begin
                    $display("mismatch step=%s expected=%h actual=%h",
                             exp_name_q[0], exp_vec_q[0], result_vec_o);
                    value_errors++;
                end
                results_checked++;
                pop_expected();
            end
        end else if (exp_vec_q.size() != 0 && exp_due_q[0] <= cycle) begin
            $display("result_valid_o stayed low in cycle %0d, result of step %s is missing",
                     cycle, exp_name_q[0]);
            protocol_errors++;
            pop_expected();
        end
    endtask

    // what the DUT does with the inputs it samples at the next edge
    task automatic update_model();
        logic was_ready;
        was_ready = model_ready;
        if (weight_load_i && !(was_ready && busy != 0)) begin
            // each accepted row pushes the held rows one array row down
            for (int r = PE_SIZE - 1; r > 0; r--) begin
                model_w[r] = model_w[r-1];
            end
            model_w[0] = weight_row_i;
            model_rows = was_ready ? 1 : model_rows + 1;
            if (model_rows == PE_SIZE) begin
                model_ready = 1'b1;
                model_rows  = 0;
            end else begin
                model_ready = 1'b0;
            end
        end
        if (cur_op == OP_VEC && !was_ready) begin
            $display("step %s found the weights not ready, vector dropped", cur_name);
            protocol_errors++;
        end
        if (cur_op == OP_VEC_NOT_READY && was_ready) begin
            $display("step %s found the weights ready, vector should be ignored", cur_name);
            protocol_errors++;
        end
        if (ifmap_valid_i && was_ready) begin
            exp_vec_q.push_back(matvec(ifmap_vec_i));
            exp_due_q.push_back(cycle + LATENCY);
            exp_name_q.push_back(cur_name);
        end
    endtask

    // outputs and driven inputs are both settled at the falling edge
    always @(negedge clk) begin
        if (!reset_i) begin
            busy = exp_vec_q.size();
            check_outputs();
            update_model();
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > max_cycles) begin
            $display("timeout after %0d cycles with %0d results still pending",
                     cycle, exp_vec_q.size());
            $display("errors: %0d value mismatches, %0d protocol errors, %0d results checked",
                     value_errors, protocol_errors, results_checked);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        clk             = 1'b0;
        reset_i         = 1'b1;
        weight_load_i   = 1'b0;
        weight_row_i    = '0;
        ifmap_valid_i   = 1'b0;
        ifmap_vec_i     = '0;
        seed            = 32'hfd36_586e;
        cycle           = 0;
        value_errors    = 0;
        protocol_errors = 0;
        results_checked = 0;
        model_ready     = 1'b0;
        model_rows      = 0;
        cur_name        = "reset";
        cur_op          = OP_IDLE;
        for (int r = 0; r < PE_SIZE; r++) begin
            model_w[r] = '0;
        end
        num_steps = 0;
        build_table();
        max_cycles = num_steps + 4 * PE_SIZE + 24;

        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < num_steps; i++) begin
            drive_step(i);
        end

        // wait for the pipeline to empty, bounded by the cycle counter
        drive_idle();
        while (exp_vec_q.size() != 0) begin
            @(posedge clk);
        end
        // room for a stray result to show up
        repeat (2 * PE_SIZE) @(posedge clk);
        @(negedge clk);

        $display("errors: %0d value mismatches, %0d protocol errors, %0d results checked",
                 value_errors, protocol_errors, results_checked);
        if (value_errors == 0 && protocol_errors == 0 && results_checked > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+hw
hw/sa_pkg.sv
hw/pe.sv
hw/systolic_array.sv
hw/skew_buffer.sv
hw/sa_controller.sv
hw/sa_top.sv
testbench/sa_assert.sv
testbench/sa_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the systolic array testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module sa_tb -f compile.f \
    --Mdir obj_dir -o sa_tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sa_tb_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1
